// File: lsu_pkg.sv
/* Load/store unit shared types */

package lsu_pkg;

   // **************************************************
   // Memory map defaults
   // **************************************************
   parameter logic [31:0] DCCM_BASE_DEFAULT      = 32'hF004_0000; // Start of local data memory
   parameter int          DCCM_ADDR_BITS_DEFAULT = 10;            // 1 KiB, 256 words

   // Access size
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_e;

   // Request as issued by the core
   typedef struct packed {
      logic        store;   // 1 = store, 0 = load
      lsu_size_e   size;
      logic        uns;     // Zero-extend load data
      logic [31:0] base;    // rs1 operand
      logic [11:0] offset;  // Immediate, sign-extended later
      logic [31:0] wdata;   // Store data, low aligned
   } lsu_req_t;

   // Control that rides along with an operation through either path
   typedef struct packed {
      logic        store;
      lsu_size_e   size;
      logic        uns;
      logic [1:0]  byte_off; // Low address bits for load alignment
      logic        err;      // Misaligned, no memory access
   } lsu_op_t;

   typedef struct packed {
      lsu_op_t     op;
      logic [29:0] waddr;    // Word address
      logic [31:0] wdata;    // Store data already in its byte lanes
      logic [3:0]  be;       // Byte enables
   } lsu_path_req_t;

   typedef struct packed {
      lsu_op_t     op;
      logic [31:0] rdata;    // Raw word, not yet aligned
   } lsu_path_rsp_t;

   // External bus request
   typedef struct packed {
      logic [29:0] waddr;
      logic        write;
      logic [31:0] wdata;
      logic [3:0]  strb;
   } lsu_bus_req_t;

   typedef struct packed {
      logic [31:0] data;
      logic        err;
   } lsu_result_t;

endpackage

// File: lsu_stage_reg.sv
/* Valid/ready pipeline register */

`timescale 1ns/100ps

module lsu_stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic full; // Entry holds a payload

   // Free slot, or the current content leaves on this edge
   assign in_ready  = ~full | out_ready;
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (reset) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;              // Refill or drain
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

// File: lsu_addr_ctl.sv
/* Address generation and in-order dispatch */

`timescale 1ns/100ps

module lsu_addr_ctl #(
   parameter logic [31:0] DCCM_BASE      = lsu_pkg::DCCM_BASE_DEFAULT,
   parameter int          DCCM_ADDR_BITS = lsu_pkg::DCCM_ADDR_BITS_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  lsu_pkg::lsu_req_t     req,
   output logic                  dccm_valid,
   input  logic                  dccm_ready,
   output lsu_pkg::lsu_path_req_t dccm_req,
   output logic                  bus_valid,
   input  logic                  bus_ready,
   output lsu_pkg::lsu_path_req_t bus_req,
   input  logic                  retire
);

   import lsu_pkg::*;

   logic [31:0]   ea;        // Effective byte address
   logic          in_dccm;
   logic          misalign;
   logic          to_bus;    // Steer to the external path
   logic [3:0]    be_base;   // Enables before lane shift
   logic          path_rdy;
   logic          issue_ok;
   logic          accept;
   logic          last_bus;  // Path of the previous issue
   logic [1:0]    cnt;       // Results outstanding
   lsu_path_req_t preq;

   // **************************************************
   // Address and region decode
   // **************************************************
   assign ea       = req.base + {{20{req.offset[11]}}, req.offset};
   assign in_dccm  = (ea[31:DCCM_ADDR_BITS] == DCCM_BASE[31:DCCM_ADDR_BITS]);
   assign misalign = ((req.size == SZ_HALF) && ea[0]) ||
                     ((req.size == SZ_WORD) && (ea[1:0] != 2'b00));
   assign to_bus   = ~in_dccm & ~misalign;     // Errors always finish on the DCCM path

   always_comb begin
      case (req.size)
         SZ_BYTE: be_base = 4'b0001;
         SZ_HALF: be_base = 4'b0011;
         default: be_base = 4'b1111;
      endcase
   end

   // Path packet, same content to both paths
   always_comb begin
      preq.op.store    = req.store;
      preq.op.size     = req.size;
      preq.op.uns      = req.uns;
      preq.op.byte_off = ea[1:0];
      preq.op.err      = misalign;
      preq.waddr       = ea[31:2];
      preq.wdata       = req.wdata << {ea[1:0], 3'b000};  // Move into byte lanes
      preq.be          = misalign ? 4'b0000 : (be_base << ea[1:0]);
   end

   assign dccm_req = preq;
   assign bus_req  = preq;

   // **************************************************
   // Ordering, switch paths only when drained
   // **************************************************
   // Closed while reset is high
   assign issue_ok   = ~reset && (cnt != 2'd3) && ((cnt == 2'd0) || (to_bus == last_bus));
   assign path_rdy   = to_bus ? bus_ready : dccm_ready;
   assign req_ready  = issue_ok & path_rdy;
   assign dccm_valid = req_valid & issue_ok & ~to_bus;
   assign bus_valid  = req_valid & issue_ok & to_bus;
   assign accept     = req_valid & req_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         last_bus <= 1'b0;
         cnt      <= 2'd0;
      end else begin
         if (accept) begin
            last_bus <= to_bus;
         end
         cnt <= cnt + {1'b0, accept} - {1'b0, retire};  // Never above 3
      end
   end

endmodule

// File: lsu_dccm_path.sv
/* DCCM RAM and access pipeline */

`timescale 1ns/100ps

module lsu_dccm_path #(
   parameter int DCCM_ADDR_BITS = lsu_pkg::DCCM_ADDR_BITS_DEFAULT
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  lsu_pkg::lsu_path_req_t in_req,
   output logic                   out_valid,
   input  logic                   out_ready,
   output lsu_pkg::lsu_path_rsp_t out_rsp
);

   import lsu_pkg::*;

   localparam int WORDS = 2 ** (DCCM_ADDR_BITS - 2);

   logic [31:0]               mem [WORDS];  // Word array, byte writable
   logic [DCCM_ADDR_BITS-3:0] idx;
   logic                      ram_en;       // Access on stage 1 load
   logic [31:0]               rd_q;         // Read word, held while stage 1 waits
   logic                      s1_valid;
   logic                      s1_ready;
   lsu_op_t                   s1_op;
   lsu_path_rsp_t             s2_in;

   assign idx    = in_req.waddr[DCCM_ADDR_BITS-3:0];
   assign ram_en = in_valid & in_ready & ~in_req.op.err;  // Misaligned ops skip the RAM

   // **************************************************
   // Stage 1, operation register and RAM access
   // **************************************************
   lsu_stage_reg #(
      .payload_t (lsu_op_t)
   ) u_stage1 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_req.op),
      .out_valid (s1_valid),
      .out_ready (s1_ready),
      .out_data  (s1_op)
   );

   always_ff @(posedge clk) begin
      if (ram_en) begin
         if (in_req.op.store) begin
            for (int b = 0; b < 4; b++) begin
               if (in_req.be[b]) begin
                  mem[idx][8*b +: 8] <= in_req.wdata[8*b +: 8];
               end
            end
         end else begin
            rd_q <= mem[idx];             // Synchronous read
         end
      end
   end

   // Stage 2 pairs the read word with its operation
   assign s2_in.op    = s1_op;
   assign s2_in.rdata = rd_q;

   lsu_stage_reg #(
      .payload_t (lsu_path_rsp_t)
   ) u_stage2 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (s1_valid),
      .in_ready  (s1_ready),
      .in_data   (s2_in),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_rsp)
   );

endmodule

// File: lsu_bus_path.sv
/* External bus access control */

`timescale 1ns/100ps

module lsu_bus_path (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  lsu_pkg::lsu_path_req_t in_req,
   output logic                   bus_req_valid,
   input  logic                   bus_req_ready,
   output lsu_pkg::lsu_bus_req_t  bus_req,
   input  logic                   bus_rsp_valid,
   input  logic [31:0]            bus_rsp_data,
   output logic                   out_valid,
   input  logic                   out_ready,
   output lsu_pkg::lsu_path_rsp_t out_rsp
);

   import lsu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_REQ  = 2'd1,   // Request presented on the bus
      ST_WAIT = 2'd2    // Waiting for the response strobe
   } state_e;

   state_e        state;
   lsu_op_t       op_q;          // Operation of the transaction in flight
   logic          stg_in_ready;
   logic          cap_valid;
   lsu_path_rsp_t cap;

   // New work only once the held result is gone
   assign in_ready      = (state == ST_IDLE) & stg_in_ready;
   assign bus_req_valid = (state == ST_REQ);
   assign cap_valid     = (state == ST_WAIT) & bus_rsp_valid;
   assign cap.op        = op_q;
   assign cap.rdata     = bus_rsp_data;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (in_valid && in_ready) state <= ST_REQ;
            ST_REQ:  if (bus_req_ready)        state <= ST_WAIT;
            ST_WAIT: if (bus_rsp_valid)        state <= ST_IDLE;  // Reads and writes both answer
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request payload, held stable while presented
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         op_q          <= in_req.op;
         bus_req.waddr <= in_req.waddr;
         bus_req.write <= in_req.op.store;
         bus_req.wdata <= in_req.wdata;
         bus_req.strb  <= in_req.be;
      end
   end

   // Result register, valid the cycle after the strobe
   lsu_stage_reg #(
      .payload_t (lsu_path_rsp_t)
   ) u_rsp_reg (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (cap_valid),
      .in_ready  (stg_in_ready),
      .in_data   (cap),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_rsp)
   );

endmodule

// File: lsu_result_merge.sv
/* Result select and load formatting */

`timescale 1ns/100ps

module lsu_result_merge (
   input  logic                   dccm_valid,
   output logic                   dccm_ready,
   input  lsu_pkg::lsu_path_rsp_t dccm_rsp,
   input  logic                   bus_valid,
   output logic                   bus_ready,
   input  lsu_pkg::lsu_path_rsp_t bus_rsp,
   output logic                   res_valid,
   input  logic                   res_ready,
   output lsu_pkg::lsu_result_t   res,
   output logic                   retire
);

   import lsu_pkg::*;

   lsu_path_rsp_t sel;      // Response of the active path
   logic [31:0]   lane;     // Addressed bytes moved to bit 0
   logic [31:0]   ld_data;
   logic          no_data;  // Store or error

   // At most one path holds a result, dispatch guarantees it
   assign sel        = bus_valid ? bus_rsp : dccm_rsp;
   assign res_valid  = dccm_valid | bus_valid;
   assign dccm_ready = res_ready & ~bus_valid;
   assign bus_ready  = res_ready & bus_valid;
   assign retire     = res_valid & res_ready;   // One pulse per result taken

   // **************************************************
   // Load alignment and extension
   // **************************************************
   assign lane = sel.rdata >> {sel.op.byte_off, 3'b000};

   always_comb begin
      case (sel.op.size)
         SZ_BYTE: begin
            ld_data = sel.op.uns ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
         end
         SZ_HALF: begin
            ld_data = sel.op.uns ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
         end
         default: begin
            ld_data = lane;                    // Word, offset is zero
         end
      endcase
   end

   assign no_data = sel.op.store | sel.op.err;

   always_comb begin
      res.data = no_data ? 32'b0 : ld_data;
      res.err  = sel.op.err;
   end

endmodule

// File: lsu_top.sv
/* Load/store unit top level */

`timescale 1ns/100ps

module lsu_top #(
   parameter logic [31:0] DCCM_BASE      = lsu_pkg::DCCM_BASE_DEFAULT,
   parameter int          DCCM_ADDR_BITS = lsu_pkg::DCCM_ADDR_BITS_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  lsu_pkg::lsu_req_t     req,
   output logic                  res_valid,
   input  logic                  res_ready,
   output lsu_pkg::lsu_result_t  res,
   output logic                  bus_req_valid,
   input  logic                  bus_req_ready,
   output lsu_pkg::lsu_bus_req_t bus_req,
   input  logic                  bus_rsp_valid,
   input  logic [31:0]           bus_rsp_data
);

   import lsu_pkg::*;

   logic          dccm_in_valid, dccm_in_ready;   // Dispatch to DCCM path
   lsu_path_req_t dccm_in_req;
   logic          bus_in_valid, bus_in_ready;     // Dispatch to bus path
   lsu_path_req_t bus_in_req;
   logic          dccm_out_valid, dccm_out_ready; // Paths to merger
   lsu_path_rsp_t dccm_out_rsp;
   logic          bus_out_valid, bus_out_ready;
   lsu_path_rsp_t bus_out_rsp;
   logic          retire;

   lsu_addr_ctl #(.DCCM_BASE(DCCM_BASE), .DCCM_ADDR_BITS(DCCM_ADDR_BITS)) u_addr_ctl (
      .clk(clk), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .dccm_valid(dccm_in_valid), .dccm_ready(dccm_in_ready), .dccm_req(dccm_in_req),
      .bus_valid(bus_in_valid), .bus_ready(bus_in_ready), .bus_req(bus_in_req),
      .retire(retire)
   );

   lsu_dccm_path #(.DCCM_ADDR_BITS(DCCM_ADDR_BITS)) u_dccm_path (
      .clk(clk), .reset(reset),
      .in_valid(dccm_in_valid), .in_ready(dccm_in_ready), .in_req(dccm_in_req),
      .out_valid(dccm_out_valid), .out_ready(dccm_out_ready), .out_rsp(dccm_out_rsp)
   );

   lsu_bus_path u_bus_path (
      .clk(clk), .reset(reset),
      .in_valid(bus_in_valid), .in_ready(bus_in_ready), .in_req(bus_in_req),
      .bus_req_valid(bus_req_valid), .bus_req_ready(bus_req_ready), .bus_req(bus_req),
      .bus_rsp_valid(bus_rsp_valid), .bus_rsp_data(bus_rsp_data),
      .out_valid(bus_out_valid), .out_ready(bus_out_ready), .out_rsp(bus_out_rsp)
   );

   lsu_result_merge u_merge (
      .dccm_valid(dccm_out_valid), .dccm_ready(dccm_out_ready), .dccm_rsp(dccm_out_rsp),
      .bus_valid(bus_out_valid), .bus_ready(bus_out_ready), .bus_rsp(bus_out_rsp),
      .res_valid(res_valid), .res_ready(res_ready), .res(res),
      .retire(retire)
   );

endmodule

// File: tb_lsu.sv
/* LSU testbench */

`timescale 1ns/100ps

module tb_lsu;

   import lsu_pkg::*;

   localparam int MAX_CASES = 64;

   logic          clk;
   logic          reset;
   logic          req_valid;
   logic          req_ready;
   lsu_req_t      req;
   logic          res_valid;
   logic          res_ready;
   lsu_result_t   res;
   logic          bus_req_valid;
   logic          bus_req_ready;
   lsu_bus_req_t  bus_req;
   logic          bus_rsp_valid;
   logic [31:0]   bus_rsp_data;

   lsu_req_t      case_req [MAX_CASES];
   lsu_result_t   case_exp [MAX_CASES];
   lsu_result_t   exp_q [$];       // Results owed, issue order
   lsu_bus_req_t  bus_q [$];       // Bus requests owed
   int            n_cases;
   int            issued;          // Requests taken by the DUT
   int            cycles;
   int            limit;
   int            fd;
   string         line;
   logic [31:0]   f_op, f_size, f_uns, f_base, f_off, f_wdata, f_data, f_err;
   logic [31:0]   rng;
   logic [1:0]    acc_cnt;         // Bus accept delay left
   logic [2:0]    rsp_cnt;         // Bus response delay left
   logic          rsp_pend;
   logic [29:0]   rsp_waddr;
   logic          bus_taken;       // Sampled on the falling edge
   logic          bus_seen;

   lsu_top dut (
      .clk(clk), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req(req),
      .res_valid(res_valid), .res_ready(res_ready), .res(res),
      .bus_req_valid(bus_req_valid), .bus_req_ready(bus_req_ready), .bus_req(bus_req),
      .bus_rsp_valid(bus_rsp_valid), .bus_rsp_data(bus_rsp_data)
   );

   always #10 clk = ~clk;   // 20 ns period

   // **************************************************
   // Helpers
   // **************************************************
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] eff_addr(input lsu_req_t r);
      return r.base + {{20{r.offset[11]}}, r.offset};   // Base plus signed offset
   endfunction

   // Aligned access outside the DCCM window
   function automatic logic goes_to_bus(input lsu_req_t r, input logic err);
      logic [31:0] ea;
      ea = eff_addr(r);
      return !err && ((ea < DCCM_BASE_DEFAULT) ||
                      (ea >= DCCM_BASE_DEFAULT + (32'd1 << DCCM_ADDR_BITS_DEFAULT)));
   endfunction

   function automatic lsu_bus_req_t expect_bus(input lsu_req_t r);
      logic [31:0]  ea;
      lsu_bus_req_t b;
      ea      = eff_addr(r);
      b.waddr = ea[31:2];
      b.write = r.store;
      b.wdata = r.wdata << (8 * ea[1:0]);   // Data in its byte lanes
      case (r.size)
         SZ_BYTE: b.strb = 4'b0001 << ea[1:0];
         SZ_HALF: b.strb = 4'b0011 << ea[1:0];
         default: b.strb = 4'b1111;
      endcase
      return b;
   endfunction

   task automatic abort_run(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_result(input lsu_result_t got, input lsu_result_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: res got data %h err %b, expected data %h err %b",
                  $time, got.data, got.err, exp.data, exp.err);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_bus_req(input lsu_bus_req_t got, input lsu_bus_req_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: bus_req got %h, expected %h", $time, got, exp);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   function automatic logic run_complete();
      return (issued == n_cases) && (exp_q.size() == 0) && (bus_q.size() == 0);
   endfunction

   // **************************************************
   // Falling edge, sample handshakes and check
   // **************************************************
   always @(negedge clk) begin
      if (reset) begin
         if ((res_valid !== 1'b0) || (bus_req_valid !== 1'b0) || (req_ready !== 1'b0))
            abort_run("a valid or ready output is high during reset");
      end else begin
         if (req_valid && req_ready) begin                  // Taken on the next rising edge
            exp_q.push_back(case_exp[issued]);
            if (goes_to_bus(case_req[issued], case_exp[issued].err))
               bus_q.push_back(expect_bus(case_req[issued]));
            issued++;
         end
         if (res_valid && res_ready) begin
            if (exp_q.size() == 0)
               abort_run("result delivered with no request outstanding");
            else
               check_result(res, exp_q.pop_front());
         end
         bus_taken = bus_req_valid && bus_req_ready;
         bus_seen  = bus_req_valid;
         if (bus_taken) begin
            if (bus_q.size() == 0)
               abort_run("bus request that no operation should make");
            else
               check_bus_req(bus_req, bus_q.pop_front());
            rsp_waddr = bus_req.waddr;                       // Kept for the answer
         end
      end
   end

   // **************************************************
   // Rising edge, request driver and bus model
   // **************************************************
   always @(posedge clk) begin
      if (!reset) begin
         if (issued < n_cases) begin
            req_valid <= 1'b1;
            req       <= case_req[issued];
         end else begin
            req_valid <= 1'b0;
         end
         rng = xorshift(rng);
         res_ready     <= (rng[1:0] != 2'b00);               // Low about one cycle in four
         bus_rsp_valid <= 1'b0;
         if (bus_taken) begin
            rng = xorshift(rng);
            bus_req_ready <= (rng[1:0] == 2'd0);             // Next accept delay 0 to 3
            acc_cnt       <= rng[1:0] - 2'd1;
            rsp_cnt       <= {1'b0, rng[3:2]} + 3'd1;        // Answer 1 to 4 cycles later
            rsp_pend      <= 1'b1;
         end else if (bus_seen && !bus_req_ready) begin
            if (acc_cnt == 2'd0)
               bus_req_ready <= 1'b1;
            else
               acc_cnt <= acc_cnt - 2'd1;
         end
         if (rsp_pend) begin
            if (rsp_cnt == 3'd1) begin
               bus_rsp_valid <= 1'b1;
               bus_rsp_data  <= {rsp_waddr, 2'b00} ^ 32'h5A5A_5A5A;
               rsp_pend      <= 1'b0;
            end else begin
               rsp_cnt <= rsp_cnt - 3'd1;
            end
         end
      end
   end

   initial begin
      clk           = 1'b0;
      reset         = 1'b1;
      req_valid     = 1'b0;
      req           = '0;
      res_ready     = 1'b0;
      bus_req_ready = 1'b0;
      bus_rsp_valid = 1'b0;
      bus_rsp_data  = '0;
      rng           = 32'd17;   // Seed
      issued        = 0;
      acc_cnt       = 2'd0;
      rsp_cnt       = 3'd0;
      rsp_pend      = 1'b0;
      rsp_waddr     = '0;
      bus_taken     = 1'b0;
      bus_seen      = 1'b0;

      // Case file, comment lines fail the scan and are skipped
      n_cases = 0;
      fd = $fopen("tb_lsu_cases.txt", "r");
      if (fd == 0)
         abort_run("cannot open tb_lsu_cases.txt");
      while (!$feof(fd) && (n_cases < MAX_CASES)) begin
         line = "";
         void'($fgets(line, fd));
         if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_op, f_size, f_uns, f_base,
                     f_off, f_wdata, f_data, f_err) == 8) begin
            case_req[n_cases].store  = f_op[0];
            case_req[n_cases].size   = lsu_size_e'(f_size[1:0]);
            case_req[n_cases].uns    = f_uns[0];
            case_req[n_cases].base   = f_base;
            case_req[n_cases].offset = f_off[11:0];
            case_req[n_cases].wdata  = f_wdata;
            case_exp[n_cases].data   = f_data;
            case_exp[n_cases].err    = f_err[0];
            n_cases++;
         end
      end
      $fclose(fd);
      if (n_cases == 0)
         abort_run("no cases found in tb_lsu_cases.txt");

      repeat (2) @(posedge clk);
      reset <= 1'b0;

      limit  = n_cases * 40 + 100;
      cycles = 0;
      while (!run_complete() && (cycles < limit)) begin
         @(posedge clk);
         cycles++;
      end

      if (run_complete()) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("Timeout after %0d cycles with %0d of %0d requests taken",
                  cycles, issued, n_cases);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

endmodule

// File: tb_lsu_cases.txt
# op size uns base offset wdata exp_data exp_err, all hex; op 1 = store; size 0/1/2 = b/h/w
# DCCM is F0040000 to F00403FF; bus reads return (word address << 2) ^ 5A5A5A5A
1 2 0 F0040000 010 DEADBEEF 00000000 0
0 2 0 F0040000 010 00000000 DEADBEEF 0
1 2 0 F0040020 000 80FF7F01 00000000 0
0 0 0 F0040020 000 00000000 00000001 0
0 0 0 F0040020 001 00000000 0000007F 0
0 0 0 F0040020 002 00000000 FFFFFFFF 0
0 0 0 F0040020 003 00000000 FFFFFF80 0
0 0 1 F0040020 003 00000000 00000080 0
0 1 0 F0040020 000 00000000 00007F01 0
0 1 0 F0040020 002 00000000 FFFF80FF 0
1 0 0 F0040020 001 000000AA 00000000 0
1 1 0 F0040020 002 00001234 00000000 0
0 2 0 F0040030 FF0 00000000 1234AA01 0
1 1 0 F0040010 001 FFFFFFFF 00000000 1
0 2 0 F0040010 002 00000000 00000000 1
1 2 0 F0040010 003 12345678 00000000 1
0 2 0 F0040010 000 00000000 DEADBEEF 0
0 2 0 80001000 000 00000000 DA5A4A5A 0
0 0 0 80001000 003 00000000 FFFFFFDA 0
0 1 0 80001000 002 00000000 FFFFDA5A 0
0 1 0 80001000 001 00000000 00000000 1
0 2 0 00000200 FFC 00000000 5A5A5BA6 0
0 2 0 F0040400 000 00000000 AA5E5E5A 0
0 2 0 F0040020 000 00000000 1234AA01 0
1 0 0 80001000 002 000000C3 00000000 0
1 1 0 80001000 006 0000BEEF 00000000 0

// File: tb.f
lsu_pkg.sv
lsu_stage_reg.sv
lsu_addr_ctl.sv
lsu_dccm_path.sv
lsu_bus_path.sv
lsu_result_merge.sv
lsu_top.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - lsu_pkg.sv
      - lsu_stage_reg.sv
      - lsu_addr_ctl.sv
      - lsu_dccm_path.sv
      - lsu_bus_path.sv
      - lsu_result_merge.sv
      - lsu_top.sv
  - target: simulation
    files:
      - tb_lsu.sv
